// ==== build.f ====
+incdir+.
decode_pkg.sv
instr_match.sv
imm_gen.sv
uop_builder.sv
uop_slot.sv
decode_stage.sv
tb_decode_stage.sv

// ==== tb_decode_ref.svh ====
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// encoders, fields laid out as in the rv32i base formats.
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

// expected micro-op of a legal instruction, pc, taken and tag filled in later.
function automatic decode_pkg::uop_t expect_uop(
    input logic [31:0] instr,
    input logic [31:0] imm,
    input logic rs1_en,
    input logic rs2_en,
    input decode_pkg::opnd_sel_e op1,
    input decode_pkg::opnd_sel_e op2,
    input decode_pkg::alu_op_e alu,
    input decode_pkg::branch_e br,
    input decode_pkg::mem_op_e mem,
    input decode_pkg::wb_sel_e wb
);
    decode_pkg::uop_t u;
    u = '0;
    u.rs1 = instr[19:15];
    u.rs2 = instr[24:20];
    u.rd = instr[11:7];
    u.rs1_en = rs1_en;
    u.rs2_en = rs2_en;
    u.imm = imm;
    u.op1_sel = op1;
    u.op2_sel = op2;
    u.alu_op = alu;
    u.branch_op = br;
    u.mem_op = mem;
    u.wb_sel = wb;
    u.rd_en = (instr[6:0] != 7'h63) && (instr[6:0] != 7'h23); // branches and stores write nothing.
    return u;
endfunction

`endif

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module tb_decode_stage;

    localparam int MAX_CYCLES = 2000;

    logic               clk_i;
    logic               rstn_i;
    logic               flush_i;
    decode_pkg::fetch_t fetch_i;
    logic               fetch_valid_i;
    logic               fetch_ready_o;
    decode_pkg::uop_t   uop_o;
    logic               uop_valid_o;
    logic               uop_ready_i;

    integer                seed;
    int                    errors;
    int                    checks;
    int                    tests;
    int                    cycles;
    logic [`DEC_TAG_W-1:0] tag_cnt; // model of the running tag.

    decode_stage dut_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .fetch_i       (fetch_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_o (fetch_ready_o),
        .uop_o         (uop_o),
        .uop_valid_o   (uop_valid_o),
        .uop_ready_i   (uop_ready_i)
    );

    `include "tb_decode_ref.svh"

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [119:0] got,
                             input logic [119:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, got %0h", name, exp, got);
        end
    endtask

    task automatic wrap_fetch(input logic [`DEC_XLEN-1:0] instr, inout decode_pkg::uop_t exp,
                              output decode_pkg::fetch_t f);
        f.instr = instr;
        f.pc = $random(seed);
        f.pc[1:0] = 2'b00;
        f.taken = $random(seed);
        exp.pc = f.pc;
        exp.taken = f.taken;
        exp.tag = tag_cnt;
    endtask

    // holds valid until the stage takes the word, returns on the next falling edge.
    task automatic send(input decode_pkg::fetch_t f);
        @(negedge clk_i);
        fetch_i = f;
        fetch_valid_i = 1'b1;
        #1;
        while (!fetch_ready_o)
        begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        fetch_valid_i = 1'b0;
    endtask

    task automatic send_check(input decode_pkg::fetch_t f, input decode_pkg::uop_t exp);
        send(f);
        check_val("uop_valid_o", uop_valid_o, 1'b1);
        check_val("uop_o", uop_o, exp);
        if (!exp.illegal)
        begin
            tag_cnt = tag_cnt + 1'b1;
        end
    endtask

    task automatic decode_check(input logic [`DEC_XLEN-1:0] instr, input decode_pkg::uop_t exp);
        decode_pkg::fetch_t f;
        wrap_fetch(instr, exp, f);
        send_check(f, exp);
    endtask

    task automatic random_addi(output decode_pkg::fetch_t f, output decode_pkg::uop_t exp);
        logic [11:0]          imm12;
        logic [`DEC_XLEN-1:0] instr;
        imm12 = $random(seed);
        instr = enc_i(imm12, $random(seed), 3'd0, $random(seed), 7'h13);
        exp = expect_uop(instr, {{20{imm12[11]}}, imm12}, 1'b1, 1'b0, decode_pkg::OPND_RS1,
                         decode_pkg::OPND_IMM, decode_pkg::ALU_ADD, decode_pkg::BR_NONE,
                         decode_pkg::MEM_NONE, decode_pkg::WB_ALU);
        wrap_fetch(instr, exp, f);
    endtask

    task automatic test_reset();
        decode_pkg::fetch_t f;
        decode_pkg::uop_t   exp;
        check_val("uop_valid_o", uop_valid_o, 1'b0);
        check_val("fetch_ready_o", fetch_ready_o, 1'b1);
        random_addi(f, exp);
        send_check(f, exp);
        check_val("uop_o.tag", uop_o.tag, 4'h0);
    endtask

    task automatic test_alu();
        logic [2:0]          f3_r [7] = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        logic [2:0]          f3_i [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        decode_pkg::alu_op_e ops [9] = '{decode_pkg::ALU_ADD, decode_pkg::ALU_SLT,
            decode_pkg::ALU_SLTU, decode_pkg::ALU_XOR, decode_pkg::ALU_OR, decode_pkg::ALU_AND,
            decode_pkg::ALU_SLL, decode_pkg::ALU_SRL, decode_pkg::ALU_SRA};
        decode_pkg::alu_op_e op;
        logic [11:0]          imm12;
        logic [`DEC_XLEN-1:0] instr;
        logic [`DEC_XLEN-1:0] imm;
        for (int i = 0; i < 7; i++)
        begin
            op = (i == 0) ? decode_pkg::ALU_ADD : (i == 1) ? decode_pkg::ALU_SUB : ops[i - 1];
            instr = enc_r((i == 1) ? 7'h20 : 7'h00, $random(seed), $random(seed), f3_r[i],
                          $random(seed));
            decode_check(instr, expect_uop(instr, '0, 1'b1, 1'b1, decode_pkg::OPND_RS1,
                decode_pkg::OPND_RS2, op, decode_pkg::BR_NONE, decode_pkg::MEM_NONE,
                decode_pkg::WB_ALU));
        end
        for (int i = 0; i < 9; i++)
        begin
            imm12 = $random(seed);
            imm = {{20{imm12[11]}}, imm12};
            if (i >= 6)
            begin
                imm12[11:5] = (i == 8) ? 7'h20 : 7'h00; // srai sets bit 30.
                imm = {27'b0, imm12[4:0]};
            end
            instr = enc_i(imm12, $random(seed), f3_i[i], $random(seed), 7'h13);
            decode_check(instr, expect_uop(instr, imm, 1'b1, 1'b0, decode_pkg::OPND_RS1,
                decode_pkg::OPND_IMM, ops[i], decode_pkg::BR_NONE, decode_pkg::MEM_NONE,
                decode_pkg::WB_ALU));
        end
    endtask

    task automatic test_control();
        logic [2:0]           f3_b [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [12:0]          b;
        logic [20:0]          j;
        logic [19:0]          u;
        logic [11:0]          imm12;
        logic [`DEC_XLEN-1:0] instr;
        for (int i = 0; i < 6; i++)
        begin
            b = $random(seed);
            b[0] = 1'b0;
            instr = enc_b(b, $random(seed), $random(seed), f3_b[i]);
            decode_check(instr, expect_uop(instr, {{19{b[12]}}, b}, 1'b1, 1'b1,
                decode_pkg::OPND_RS1, decode_pkg::OPND_RS2, decode_pkg::ALU_NOP,
                decode_pkg::branch_e'(i + 1), decode_pkg::MEM_NONE, decode_pkg::WB_NONE));
        end
        j = $random(seed);
        j[0] = 1'b0;
        instr = enc_j(j, $random(seed));
        decode_check(instr, expect_uop(instr, {{11{j[20]}}, j}, 1'b0, 1'b0,
            decode_pkg::OPND_NONE, decode_pkg::OPND_NONE, decode_pkg::ALU_NOP,
            decode_pkg::BR_JAL, decode_pkg::MEM_NONE, decode_pkg::WB_LINK));
        imm12 = $random(seed);
        instr = enc_i(imm12, $random(seed), 3'd0, $random(seed), 7'h67);
        decode_check(instr, expect_uop(instr, {{20{imm12[11]}}, imm12}, 1'b1, 1'b0,
            decode_pkg::OPND_NONE, decode_pkg::OPND_NONE, decode_pkg::ALU_NOP,
            decode_pkg::BR_JALR, decode_pkg::MEM_NONE, decode_pkg::WB_LINK));
        u = $random(seed);
        instr = {u, 5'($random(seed)), 7'h37}; // lui.
        decode_check(instr, expect_uop(instr, {u, 12'b0}, 1'b0, 1'b0, decode_pkg::OPND_IMM,
            decode_pkg::OPND_NONE, decode_pkg::ALU_NOP, decode_pkg::BR_NONE,
            decode_pkg::MEM_NONE, decode_pkg::WB_OPND1));
        u = $random(seed);
        instr = {u, 5'($random(seed)), 7'h17}; // auipc.
        decode_check(instr, expect_uop(instr, {u, 12'b0}, 1'b0, 1'b0, decode_pkg::OPND_PC,
            decode_pkg::OPND_IMM, decode_pkg::ALU_ADD, decode_pkg::BR_NONE,
            decode_pkg::MEM_NONE, decode_pkg::WB_ALU));
    endtask

    task automatic test_mem();
        logic [2:0]           f3_l [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        logic [11:0]          imm12;
        logic [`DEC_XLEN-1:0] instr;
        for (int i = 0; i < 8; i++)
        begin
            imm12 = $random(seed);
            if (i < 5)
                instr = enc_i(imm12, $random(seed), f3_l[i], $random(seed), 7'h03);
            else
                instr = enc_s(imm12, $random(seed), $random(seed), 3'(i - 5));
            decode_check(instr, expect_uop(instr, {{20{imm12[11]}}, imm12}, 1'b1, i >= 5,
                decode_pkg::OPND_RS1, decode_pkg::OPND_IMM, decode_pkg::ALU_ADD,
                decode_pkg::BR_NONE, decode_pkg::mem_op_e'(i + 1),
                (i < 5) ? decode_pkg::WB_MEM : decode_pkg::WB_NONE));
            check_val("uop_o.rd_en", uop_o.rd_en, i < 5);
        end
    endtask

    task automatic test_illegal();
        logic [`DEC_XLEN-1:0] words [4] = '{32'h0000_0073, 32'h3401_1073, 32'h0ff0_000f,
                                            32'h00a0_0090}; // ecall, csrrw, fence, low 00.
        decode_pkg::uop_t exp;
        for (int i = 0; i < 4; i++)
        begin
            exp = '0;
            exp.illegal = 1'b1;
            decode_check(words[i], exp);
        end
    endtask

    task automatic test_flow();
        decode_pkg::fetch_t fa, fb, fc, fd;
        decode_pkg::uop_t   ea, eb, ec, ed;
        @(negedge clk_i); // let the last micro-op drain.
        uop_ready_i = 1'b0;
        random_addi(fa, ea);
        send_check(fa, ea);
        check_val("fetch_ready_o", fetch_ready_o, 1'b0);
        random_addi(fb, eb);
        fetch_i = fb;
        fetch_valid_i = 1'b1;
        repeat (3)
        begin
            @(negedge clk_i);
            check_val("uop_o", uop_o, ea);
            check_val("fetch_ready_o", fetch_ready_o, 1'b0);
        end
        uop_ready_i = 1'b1;
        @(negedge clk_i);
        fetch_valid_i = 1'b0;
        check_val("uop_o", uop_o, eb);
        tag_cnt = tag_cnt + 1'b1;
        @(negedge clk_i);
        uop_ready_i = 1'b0;
        random_addi(fc, ec);
        send_check(fc, ec);
        random_addi(fd, ed);
        fetch_i = fd;
        fetch_valid_i = 1'b1;
        flush_i = 1'b1;
        #1;
        check_val("fetch_ready_o", fetch_ready_o, 1'b1);
        @(negedge clk_i);
        flush_i = 1'b0;
        fetch_valid_i = 1'b0;
        uop_ready_i = 1'b1;
        check_val("uop_valid_o", uop_valid_o, 1'b0);
        for (int i = 0; i < 18; i++)
        begin
            random_addi(fa, ea); // tag keeps counting past the flush and wraps.
            send_check(fa, ea);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    initial
    begin
        int mark;
        seed = 32'h7d031fce;
        errors = 0;
        checks = 0;
        tests = 0;
        cycles = 0;
        tag_cnt = '0;
        clk_i = 1'b0;
        rstn_i = 1'b0;
        flush_i = 1'b0;
        fetch_i = '0;
        fetch_valid_i = 1'b0;
        uop_ready_i = 1'b1;
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;
        mark = errors;
        test_reset();
        end_test("reset", mark);
        mark = errors;
        test_alu();
        end_test("op_and_op_imm", mark);
        mark = errors;
        test_control();
        end_test("control_flow", mark);
        mark = errors;
        test_mem();
        end_test("loads_stores", mark);
        mark = errors;
        test_illegal();
        end_test("illegal", mark);
        mark = errors;
        test_flow();
        end_test("backpressure_flush", mark);
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_stage (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               flush_i,
    input  decode_pkg::fetch_t fetch_i,
    input  logic               fetch_valid_i,
    output logic               fetch_ready_o,
    output decode_pkg::uop_t   uop_o,
    output logic               uop_valid_o,
    input  logic               uop_ready_i
);

    decode_pkg::instr_kind_e kind;
    decode_pkg::imm_fmt_e    fmt;
    logic [`DEC_XLEN-1:0]    imm;
    decode_pkg::uop_t        built_uop; // tag still zero here.

    instr_match u_match (
        .instr_i (fetch_i.instr),
        .kind_o  (kind),
        .fmt_o   (fmt)
    );

    imm_gen u_imm (
        .instr_i (fetch_i.instr),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    uop_builder u_builder (
        .fetch_i (fetch_i),
        .kind_i  (kind),
        .imm_i   (imm),
        .uop_o   (built_uop)
    );

    uop_slot u_slot (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .in_valid_i  (fetch_valid_i),
        .in_uop_i    (built_uop),
        .in_ready_o  (fetch_ready_o),
        .out_valid_o (uop_valid_o),
        .out_ready_i (uop_ready_i),
        .out_uop_o   (uop_o)
    );

endmodule

// ==== uop_slot.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module uop_slot (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             flush_i,
    input  logic             in_valid_i,
    input  decode_pkg::uop_t in_uop_i,
    output logic             in_ready_o,
    output logic             out_valid_o,
    input  logic             out_ready_i,
    output decode_pkg::uop_t out_uop_o
);

    logic                  full_q;
    logic [`DEC_TAG_W-1:0] tag_q;
    logic                  load;
    decode_pkg::uop_t      uop_q;
    decode_pkg::uop_t      stamped;

    assign in_ready_o = !full_q || out_ready_i || flush_i;
    assign load = in_valid_i && in_ready_o && !flush_i; // flushed input is dropped.

    always_comb
    begin
        stamped = in_uop_i;
        stamped.tag = tag_q;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            full_q <= 1'b0;
            tag_q <= '0;
        end
        else if (flush_i)
        begin
            full_q <= 1'b0;
        end
        else if (load)
        begin
            full_q <= 1'b1;
            if (!in_uop_i.illegal)
            begin
                tag_q <= tag_q + 1'b1; // wraps naturally.
            end
        end
        else if (out_ready_i)
        begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (load)
        begin
            uop_q <= stamped;
        end
    end

    assign out_valid_o = full_q;
    assign out_uop_o = uop_q;

endmodule

// ==== uop_builder.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module uop_builder (
    input  decode_pkg::fetch_t      fetch_i,
    input  decode_pkg::instr_kind_e kind_i,
    input  logic [`DEC_XLEN-1:0]   imm_i,
    output decode_pkg::uop_t        uop_o
);

    always_comb
    begin
        uop_o = '0;
        uop_o.pc = fetch_i.pc;
        uop_o.taken = fetch_i.taken;
        uop_o.illegal = (kind_i == decode_pkg::KIND_ILLEGAL);

        if (!uop_o.illegal)
        begin
            uop_o.rs1 = fetch_i.instr[19:15];
            uop_o.rs2 = fetch_i.instr[24:20];
            uop_o.rd = fetch_i.instr[11:7];
            uop_o.imm = imm_i;
        end

        // operand routing and write-back by instruction class.
        unique case (kind_i)
            decode_pkg::KIND_ADD, decode_pkg::KIND_SUB, decode_pkg::KIND_SLT,
            decode_pkg::KIND_SLTU, decode_pkg::KIND_XOR, decode_pkg::KIND_OR,
            decode_pkg::KIND_AND:
            begin
                uop_o.rs1_en = 1'b1;
                uop_o.rs2_en = 1'b1;
                uop_o.op1_sel = decode_pkg::OPND_RS1;
                uop_o.op2_sel = decode_pkg::OPND_RS2;
                uop_o.wb_sel = decode_pkg::WB_ALU;
            end
            decode_pkg::KIND_ADDI, decode_pkg::KIND_SLTI, decode_pkg::KIND_SLTIU,
            decode_pkg::KIND_XORI, decode_pkg::KIND_ORI, decode_pkg::KIND_ANDI,
            decode_pkg::KIND_SLLI, decode_pkg::KIND_SRLI, decode_pkg::KIND_SRAI:
            begin
                uop_o.rs1_en = 1'b1;
                uop_o.op1_sel = decode_pkg::OPND_RS1;
                uop_o.op2_sel = decode_pkg::OPND_IMM;
                uop_o.wb_sel = decode_pkg::WB_ALU;
            end
            decode_pkg::KIND_LUI:
            begin
                uop_o.op1_sel = decode_pkg::OPND_IMM;
                uop_o.wb_sel = decode_pkg::WB_OPND1; // no alu pass needed.
            end
            decode_pkg::KIND_AUIPC:
            begin
                uop_o.op1_sel = decode_pkg::OPND_PC;
                uop_o.op2_sel = decode_pkg::OPND_IMM;
                uop_o.wb_sel = decode_pkg::WB_ALU;
            end
            decode_pkg::KIND_JAL:
            begin
                uop_o.wb_sel = decode_pkg::WB_LINK;
            end
            decode_pkg::KIND_JALR:
            begin
                uop_o.rs1_en = 1'b1;
                uop_o.wb_sel = decode_pkg::WB_LINK;
            end
            decode_pkg::KIND_BEQ, decode_pkg::KIND_BNE, decode_pkg::KIND_BLT,
            decode_pkg::KIND_BGE, decode_pkg::KIND_BLTU, decode_pkg::KIND_BGEU:
            begin
                uop_o.rs1_en = 1'b1;
                uop_o.rs2_en = 1'b1;
                uop_o.op1_sel = decode_pkg::OPND_RS1;
                uop_o.op2_sel = decode_pkg::OPND_RS2;
            end
            decode_pkg::KIND_LB, decode_pkg::KIND_LH, decode_pkg::KIND_LW,
            decode_pkg::KIND_LBU, decode_pkg::KIND_LHU:
            begin
                uop_o.rs1_en = 1'b1;
                uop_o.op1_sel = decode_pkg::OPND_RS1;
                uop_o.op2_sel = decode_pkg::OPND_IMM;
                uop_o.wb_sel = decode_pkg::WB_MEM;
            end
            decode_pkg::KIND_SB, decode_pkg::KIND_SH, decode_pkg::KIND_SW:
            begin
                uop_o.rs1_en = 1'b1;
                uop_o.rs2_en = 1'b1; // store data.
                uop_o.op1_sel = decode_pkg::OPND_RS1;
                uop_o.op2_sel = decode_pkg::OPND_IMM;
            end
            default:
            begin
                uop_o.wb_sel = decode_pkg::WB_NONE;
            end
        endcase

        uop_o.rd_en = (uop_o.wb_sel != decode_pkg::WB_NONE);

        unique case (kind_i)
            decode_pkg::KIND_ADD, decode_pkg::KIND_ADDI, decode_pkg::KIND_AUIPC,
            decode_pkg::KIND_LB, decode_pkg::KIND_LH, decode_pkg::KIND_LW,
            decode_pkg::KIND_LBU, decode_pkg::KIND_LHU, decode_pkg::KIND_SB,
            decode_pkg::KIND_SH, decode_pkg::KIND_SW:
                uop_o.alu_op = decode_pkg::ALU_ADD; // address add for memory ops.
            decode_pkg::KIND_SUB:
                uop_o.alu_op = decode_pkg::ALU_SUB;
            decode_pkg::KIND_SLT, decode_pkg::KIND_SLTI:
                uop_o.alu_op = decode_pkg::ALU_SLT;
            decode_pkg::KIND_SLTU, decode_pkg::KIND_SLTIU:
                uop_o.alu_op = decode_pkg::ALU_SLTU;
            decode_pkg::KIND_XOR, decode_pkg::KIND_XORI:
                uop_o.alu_op = decode_pkg::ALU_XOR;
            decode_pkg::KIND_OR, decode_pkg::KIND_ORI:
                uop_o.alu_op = decode_pkg::ALU_OR;
            decode_pkg::KIND_AND, decode_pkg::KIND_ANDI:
                uop_o.alu_op = decode_pkg::ALU_AND;
            decode_pkg::KIND_SLLI:
                uop_o.alu_op = decode_pkg::ALU_SLL;
            decode_pkg::KIND_SRLI:
                uop_o.alu_op = decode_pkg::ALU_SRL;
            decode_pkg::KIND_SRAI:
                uop_o.alu_op = decode_pkg::ALU_SRA;
            default:
                uop_o.alu_op = decode_pkg::ALU_NOP;
        endcase

        unique case (kind_i)
            decode_pkg::KIND_BEQ:  uop_o.branch_op = decode_pkg::BR_BEQ;
            decode_pkg::KIND_BNE:  uop_o.branch_op = decode_pkg::BR_BNE;
            decode_pkg::KIND_BLT:  uop_o.branch_op = decode_pkg::BR_BLT;
            decode_pkg::KIND_BGE:  uop_o.branch_op = decode_pkg::BR_BGE;
            decode_pkg::KIND_BLTU: uop_o.branch_op = decode_pkg::BR_BLTU;
            decode_pkg::KIND_BGEU: uop_o.branch_op = decode_pkg::BR_BGEU;
            decode_pkg::KIND_JAL:  uop_o.branch_op = decode_pkg::BR_JAL;
            decode_pkg::KIND_JALR: uop_o.branch_op = decode_pkg::BR_JALR;
            default:               uop_o.branch_op = decode_pkg::BR_NONE;
        endcase

        unique case (kind_i)
            decode_pkg::KIND_LB:  uop_o.mem_op = decode_pkg::MEM_LB;
            decode_pkg::KIND_LH:  uop_o.mem_op = decode_pkg::MEM_LH;
            decode_pkg::KIND_LW:  uop_o.mem_op = decode_pkg::MEM_LW;
            decode_pkg::KIND_LBU: uop_o.mem_op = decode_pkg::MEM_LBU;
            decode_pkg::KIND_LHU: uop_o.mem_op = decode_pkg::MEM_LHU;
            decode_pkg::KIND_SB:  uop_o.mem_op = decode_pkg::MEM_SB;
            decode_pkg::KIND_SH:  uop_o.mem_op = decode_pkg::MEM_SH;
            decode_pkg::KIND_SW:  uop_o.mem_op = decode_pkg::MEM_SW;
            default:              uop_o.mem_op = decode_pkg::MEM_NONE;
        endcase
    end

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module imm_gen (
    input  logic [`DEC_XLEN-1:0] instr_i,
    input  decode_pkg::imm_fmt_e  fmt_i,
    output logic [`DEC_XLEN-1:0] imm_o
);

    always_comb
    begin
        unique case (fmt_i)
            decode_pkg::IMM_I:
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            decode_pkg::IMM_S:
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            decode_pkg::IMM_B:
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0}; // halfword offset.
            decode_pkg::IMM_U:
                imm_o = {instr_i[31:12], 12'b0};
            decode_pkg::IMM_J:
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            decode_pkg::IMM_SHAMT:
                imm_o = {27'b0, instr_i[24:20]}; // unsigned shift amount.
            default:
                imm_o = '0;
        endcase
    end

endmodule

// ==== instr_match.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module instr_match (
    input  logic [`DEC_XLEN-1:0]   instr_i,
    output decode_pkg::instr_kind_e kind_o,
    output decode_pkg::imm_fmt_e    fmt_o
);

    localparam logic [`DEC_XLEN-1:0] M_OPC = 32'h0000_007f; // opcode only.
    localparam logic [`DEC_XLEN-1:0] M_F3  = 32'h0000_707f; // opcode and funct3.
    localparam logic [`DEC_XLEN-1:0] M_F7  = 32'hfe00_707f; // plus funct7.

    logic [`DEC_OPC_W-1:0] opcode;

    function automatic logic hit(
        input logic [`DEC_XLEN-1:0] word,
        input logic [`DEC_XLEN-1:0] mask,
        input logic [`DEC_XLEN-1:0] value
    );
        return (word & mask) == value;
    endfunction

    assign opcode = instr_i[`DEC_OPC_W-1:0];

    // encodings are disjoint, so at most one test fires.
    always_comb
    begin
        kind_o = decode_pkg::KIND_ILLEGAL;
        if (hit(instr_i, M_OPC, 32'h0000_0037)) kind_o = decode_pkg::KIND_LUI;
        if (hit(instr_i, M_OPC, 32'h0000_0017)) kind_o = decode_pkg::KIND_AUIPC;
        if (hit(instr_i, M_OPC, 32'h0000_006f)) kind_o = decode_pkg::KIND_JAL;
        if (hit(instr_i, M_F3, 32'h0000_0067)) kind_o = decode_pkg::KIND_JALR;
        if (hit(instr_i, M_F3, 32'h0000_0063)) kind_o = decode_pkg::KIND_BEQ;
        if (hit(instr_i, M_F3, 32'h0000_1063)) kind_o = decode_pkg::KIND_BNE;
        if (hit(instr_i, M_F3, 32'h0000_4063)) kind_o = decode_pkg::KIND_BLT;
        if (hit(instr_i, M_F3, 32'h0000_5063)) kind_o = decode_pkg::KIND_BGE;
        if (hit(instr_i, M_F3, 32'h0000_6063)) kind_o = decode_pkg::KIND_BLTU;
        if (hit(instr_i, M_F3, 32'h0000_7063)) kind_o = decode_pkg::KIND_BGEU;
        if (hit(instr_i, M_F3, 32'h0000_0003)) kind_o = decode_pkg::KIND_LB;
        if (hit(instr_i, M_F3, 32'h0000_1003)) kind_o = decode_pkg::KIND_LH;
        if (hit(instr_i, M_F3, 32'h0000_2003)) kind_o = decode_pkg::KIND_LW;
        if (hit(instr_i, M_F3, 32'h0000_4003)) kind_o = decode_pkg::KIND_LBU;
        if (hit(instr_i, M_F3, 32'h0000_5003)) kind_o = decode_pkg::KIND_LHU;
        if (hit(instr_i, M_F3, 32'h0000_0023)) kind_o = decode_pkg::KIND_SB;
        if (hit(instr_i, M_F3, 32'h0000_1023)) kind_o = decode_pkg::KIND_SH;
        if (hit(instr_i, M_F3, 32'h0000_2023)) kind_o = decode_pkg::KIND_SW;
        if (hit(instr_i, M_F3, 32'h0000_0013)) kind_o = decode_pkg::KIND_ADDI;
        if (hit(instr_i, M_F3, 32'h0000_2013)) kind_o = decode_pkg::KIND_SLTI;
        if (hit(instr_i, M_F3, 32'h0000_3013)) kind_o = decode_pkg::KIND_SLTIU;
        if (hit(instr_i, M_F3, 32'h0000_4013)) kind_o = decode_pkg::KIND_XORI;
        if (hit(instr_i, M_F3, 32'h0000_6013)) kind_o = decode_pkg::KIND_ORI;
        if (hit(instr_i, M_F3, 32'h0000_7013)) kind_o = decode_pkg::KIND_ANDI;
        if (hit(instr_i, M_F7, 32'h0000_1013)) kind_o = decode_pkg::KIND_SLLI;
        if (hit(instr_i, M_F7, 32'h0000_5013)) kind_o = decode_pkg::KIND_SRLI;
        if (hit(instr_i, M_F7, 32'h4000_5013)) kind_o = decode_pkg::KIND_SRAI;
        if (hit(instr_i, M_F7, 32'h0000_0033)) kind_o = decode_pkg::KIND_ADD;
        if (hit(instr_i, M_F7, 32'h4000_0033)) kind_o = decode_pkg::KIND_SUB;
        if (hit(instr_i, M_F7, 32'h0000_2033)) kind_o = decode_pkg::KIND_SLT;
        if (hit(instr_i, M_F7, 32'h0000_3033)) kind_o = decode_pkg::KIND_SLTU;
        if (hit(instr_i, M_F7, 32'h0000_4033)) kind_o = decode_pkg::KIND_XOR;
        if (hit(instr_i, M_F7, 32'h0000_6033)) kind_o = decode_pkg::KIND_OR;
        if (hit(instr_i, M_F7, 32'h0000_7033)) kind_o = decode_pkg::KIND_AND;
        if (opcode[1:0] != 2'b11) kind_o = decode_pkg::KIND_ILLEGAL; // compressed space.
    end

    always_comb
    begin
        unique case (kind_o)
            decode_pkg::KIND_LUI, decode_pkg::KIND_AUIPC:
                fmt_o = decode_pkg::IMM_U;
            decode_pkg::KIND_JAL:
                fmt_o = decode_pkg::IMM_J;
            decode_pkg::KIND_BEQ, decode_pkg::KIND_BNE, decode_pkg::KIND_BLT,
            decode_pkg::KIND_BGE, decode_pkg::KIND_BLTU, decode_pkg::KIND_BGEU:
                fmt_o = decode_pkg::IMM_B;
            decode_pkg::KIND_SB, decode_pkg::KIND_SH, decode_pkg::KIND_SW:
                fmt_o = decode_pkg::IMM_S;
            decode_pkg::KIND_SLLI, decode_pkg::KIND_SRLI, decode_pkg::KIND_SRAI:
                fmt_o = decode_pkg::IMM_SHAMT;
            decode_pkg::KIND_JALR, decode_pkg::KIND_LB, decode_pkg::KIND_LH,
            decode_pkg::KIND_LW, decode_pkg::KIND_LBU, decode_pkg::KIND_LHU,
            decode_pkg::KIND_ADDI, decode_pkg::KIND_SLTI, decode_pkg::KIND_SLTIU,
            decode_pkg::KIND_XORI, decode_pkg::KIND_ORI, decode_pkg::KIND_ANDI:
                fmt_o = decode_pkg::IMM_I;
            default:
                fmt_o = decode_pkg::IMM_NONE; // register ops and illegal.
        endcase
    end

endmodule

// ==== decode_pkg.sv ====
`include "decode_config.svh"

package decode_pkg;

    typedef enum logic [5:0] {
        KIND_ILLEGAL,
        KIND_LUI, KIND_AUIPC, KIND_JAL, KIND_JALR,
        KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU,
        KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU,
        KIND_SB, KIND_SH, KIND_SW,
        KIND_ADDI, KIND_SLTI, KIND_SLTIU, KIND_XORI, KIND_ORI, KIND_ANDI,
        KIND_SLLI, KIND_SRLI, KIND_SRAI,
        KIND_ADD, KIND_SUB, KIND_SLT, KIND_SLTU, KIND_XOR, KIND_OR, KIND_AND
    } instr_kind_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    // shared by both operand selects.
    typedef enum logic [2:0] {
        OPND_NONE, OPND_RS1, OPND_RS2, OPND_IMM, OPND_PC
    } opnd_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } branch_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    // OPND1 forwards operand 1 untouched, used by lui.
    typedef enum logic [2:0] {
        WB_NONE, WB_ALU, WB_OPND1, WB_MEM, WB_LINK
    } wb_sel_e;

    typedef struct packed {
        logic [`DEC_XLEN-1:0] instr;
        logic [`DEC_XLEN-1:0] pc;
        logic                 taken; // predicted taken by fetch.
    } fetch_t;

    typedef struct packed {
        logic [`DEC_XLEN-1:0]  pc;
        logic [`DEC_TAG_W-1:0] tag;
        logic                  taken;
        logic                  illegal;
        logic [`DEC_REG_W-1:0] rs1;
        logic                  rs1_en;
        logic [`DEC_REG_W-1:0] rs2;
        logic                  rs2_en;
        logic [`DEC_REG_W-1:0] rd;
        logic                  rd_en;
        logic [`DEC_XLEN-1:0]  imm;
        opnd_sel_e             op1_sel;
        opnd_sel_e             op2_sel;
        alu_op_e               alu_op;
        branch_e               branch_op;
        mem_op_e               mem_op;
        wb_sel_e               wb_sel;
    } uop_t;

endpackage

// ==== decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// data path width.
`define DEC_XLEN 32

// register file address width.
`define DEC_REG_W 5

// micro-op tag width, wraps at 16.
`define DEC_TAG_W 4

// major opcode field, bits 6 to 0.
`define DEC_OPC_W 7

`endif
